/* dv/ldxPathTb.sv */
// --------------------
// directed testbench for the load path; inputs change on the falling
// edge, results are sampled one falling edge later
// --------------------
`timescale 1ns/10ps

module ldxPathTb;
	import ldxPkg::*;

	localparam int LOAD_TIMEOUT = 8;   // cycles to wait for loadValid_o
	localparam int MEM_WORDS    = 16;

	logic                 clk;
	logic                 reset;
	ldPkt_t               ldPkt;
	stPkt_t               stPkt;
	dispPkt_t             dispLd;
	logic                 commitSt;
	logic                 commitLdValid;
	lsqIdx_t              commitLdIdx;
	lsqIdx_t              stqHead;
	lsqIdx_t              stqTail;
	lsqCount_t            stqCount;
	logic                 recover;
	logic [LSQ_DEPTH-1:0] addrValidRecover;
	data_t                ldData;
	logic                 ldDataValid;
	logic                 ldEn;
	addr_t                ldAddr;
	stCommit_t            stCommit;
	logic                 stEn;
	data_t                loadData;
	logic                 loadValid;
	ldVio_t               ldVio;

	data_t       mem [MEM_WORDS];
	logic        memOn;          // memory answers loads
	logic [31:0] rngState;
	seqNo_t      nextSeq;
	int          mismatchCount;
	int          failCount;

	ldxPath UUT (
		.clk                   (clk),
		.reset                 (reset),
		.ldPkt_i               (ldPkt),
		.stPkt_i               (stPkt),
		.dispLd_i              (dispLd),
		.commitSt_i            (commitSt),
		.commitLdValid_i       (commitLdValid),
		.commitLdIdx_i         (commitLdIdx),
		.stqHead_i             (stqHead),
		.stqTail_i             (stqTail),
		.stqCount_i            (stqCount),
		.recover_i             (recover),
		.stqAddrValidRecover_i (addrValidRecover),
		.ldData_i              (ldData),
		.ldDataValid_i         (ldDataValid),
		.ldEn_o                (ldEn),
		.ldAddr_o              (ldAddr),
		.stCommit_o            (stCommit),
		.stEn_o                (stEn),
		.loadData_o            (loadData),
		.loadValid_o           (loadValid),
		.ldVio_o               (ldVio)
	);

	always #5 clk = ~clk;

	// same-cycle memory, whole word back
	always_comb
	begin
		ldData      = mem[ldAddr[5:2]];
		ldDataValid = memOn && ldEn;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function data_t nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// bytes of the access moved down, then extended to 32 bits
	function automatic data_t extendLoad(input data_t word, input offset_t off,
		input ldstSize_e size, input logic sign);
		data_t lane;
		lane = word >> {off, 3'b000};
		case (size)
			SZ_BYTE: return sign ? {{24{lane[7]}}, lane[7:0]} : {24'h0, lane[7:0]};
			SZ_HALF: return sign ? {{16{lane[15]}}, lane[15:0]} : {16'h0, lane[15:0]};
			default: return lane;
		endcase
	endfunction

	function automatic byteEn_t byteEnFor(input ldstSize_e size, input offset_t off);
		byteEn_t en;
		int      nBytes;
		if (size == SZ_WORD)
			return '1;
		nBytes = (size == SZ_BYTE) ? 1 : 2;
		for (int b = 0; b < BYTE_EN_W; b++)
			en[b] = (b >= int'(off)) && (b < int'(off) + nBytes);
		return en;
	endfunction

	task automatic reportFailure(input string msg);
		failCount++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic checkData(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	task automatic checkCommit(input string name, input stCommit_t got, input stCommit_t exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic checkEn(input string name, input byteEn_t got, input byteEn_t exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	task automatic checkVio(input string name, input ldVio_t got, input ldVio_t exp);
		if (got !== exp)
		begin
			mismatchCount++;
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// store allocated at the tail and executed in the same cycle
	task automatic pushStore(input addr_t addr, input ldstSize_e size, input data_t data,
		output lsqIdx_t idx);
		@(negedge clk);
		idx      = stqTail;
		stPkt    = '{valid: 1'b1, lsqId: stqTail, addr: addr, size: size, data: data};
		stqTail  = stqTail + 1'b1;
		stqCount = stqCount + 1'b1;
		@(negedge clk);
		stPkt.valid = 1'b0;
	endtask

	task automatic allocStore(output lsqIdx_t idx);
		@(negedge clk);
		idx      = stqTail;   // address stays unknown
		stqTail  = stqTail + 1'b1;
		stqCount = stqCount + 1'b1;
	endtask

	task automatic commitHead(output stCommit_t seen, output logic seenEn);
		@(negedge clk);
		commitSt = 1'b1;
		#1;
		seen   = stCommit;
		seenEn = stEn;
		checkBit("ldEn_o", ldEn, 1'b0);   // no load in flight here
		@(negedge clk);
		commitSt = 1'b0;
		stqHead  = stqHead + 1'b1;
		stqCount = stqCount - 1'b1;
	endtask

	task automatic drainQueue();
		stCommit_t seen;
		logic      seenEn;
		for (int n = 0; n < LSQ_DEPTH && stqCount != 0; n++)
			commitHead(seen, seenEn);
		if (stqCount != 0)
			reportFailure("store queue did not drain");
	endtask

	task automatic dispatchLoad(input lsqIdx_t ldqId, input lsqIdx_t lastSt,
		input logic predVio);
		@(negedge clk);
		dispLd = '{valid: 1'b1, ldqId: ldqId, lastSt: lastSt, predVio: predVio};
		@(negedge clk);
		dispLd.valid = 1'b0;
	endtask

	// one load in, result and violation one cycle later
	task automatic runLoad(input lsqIdx_t ldqId, input addr_t addr, input ldstSize_e size,
		input logic sign, input logic expValid, input data_t expData, input logic expVio);
		seqNo_t seq;
		ldVio_t gotVio;
		int     waitCnt;
		seq     = nextSeq;
		nextSeq = nextSeq + 1'b1;
		@(negedge clk);
		ldPkt = '{valid: 1'b1, lsqId: ldqId, addr: addr, size: size, sign: sign, seqNo: seq};
		#1;
		// memory request follows the load in the same cycle
		checkBit("ldEn_o", ldEn, 1'b1);
		checkAddr("ldAddr_o", ldAddr, addr);
		checkBit("stEn_o", stEn, 1'b0);
		@(negedge clk);
		ldPkt.valid = 1'b0;
		gotVio      = ldVio;
		waitCnt     = 0;
		while (!loadValid && waitCnt < LOAD_TIMEOUT)
		begin
			@(negedge clk);
			waitCnt++;
		end
		if (expValid && loadValid !== 1'b1)
			reportFailure($sformatf("load %0d gave no result within %0d cycles", seq, waitCnt));
		else
			checkBit("loadValid_o", loadValid, expValid);
		if (expValid && loadValid === 1'b1)
			checkData("loadData_o", loadData, expData);
		checkVio("ldVio_o", gotVio, '{valid: expVio, seqNo: seq});
	endtask

	task automatic memLoad(input addr_t addr, input ldstSize_e size, input logic sign);
		runLoad(3'd0, addr, size, sign, 1'b1,
			extendLoad(mem[addr[5:2]], addr[1:0], size, sign), 1'b0);
	endtask

	task automatic testStoreCommit();
		ldstSize_e sizes [7] = '{SZ_BYTE, SZ_BYTE, SZ_BYTE, SZ_BYTE, SZ_HALF, SZ_HALF, SZ_WORD};
		offset_t   offs [7]  = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd0};
		addr_t     addrs [7];
		data_t     datas [7];
		lsqIdx_t   idx;
		stCommit_t seen;
		logic      seenEn;
		for (int i = 0; i < 7; i++)
		begin
			addrs[i] = 32'h0000_0400 + 32'(i * 8) + 32'(offs[i]);
			datas[i] = nextRand();
			pushStore(addrs[i], sizes[i], datas[i], idx);
		end
		for (int i = 0; i < 7; i++)
		begin
			commitHead(seen, seenEn);
			checkCommit("stCommit_o", seen,
				'{addr: addrs[i], data: datas[i], byteEn: byteEnFor(sizes[i], offs[i])});
			checkEn("stCommit_o.byteEn", seen.byteEn, byteEnFor(sizes[i], offs[i]));
			checkBit("stEn_o", seenEn, 1'b1);
		end
	endtask

	task automatic testMemLoad();
		for (int off = 0; off < 4; off++)
		begin
			memLoad(32'(off * 8 + off), SZ_BYTE, 1'b0);
			memLoad(32'(off * 8 + 4 + off), SZ_BYTE, 1'b1);
		end
		memLoad(32'h20, SZ_HALF, 1'b0);
		memLoad(32'h26, SZ_HALF, 1'b1);
		memLoad(32'h2a, SZ_HALF, 1'b0);
		memLoad(32'h2c, SZ_HALF, 1'b1);
		memLoad(32'h30, SZ_WORD, 1'b0);
		memLoad(32'h3c, SZ_WORD, 1'b1);
	endtask

	task automatic testForward();
		data_t   d [3];
		lsqIdx_t idx [3];
		for (int i = 0; i < 3; i++)
		begin
			d[i] = nextRand();
			pushStore(32'h20, SZ_WORD, d[i], idx[i]);
		end
		if (idx[0] < idx[1])
			reportFailure("forwarding window was expected to wrap");
		dispatchLoad(3'd1, idx[1], 1'b0);
		runLoad(3'd1, 32'h20, SZ_WORD, 1'b0, 1'b1, d[1], 1'b0);  // idx[2] is younger
		drainQueue();
		for (int i = 0; i < 3; i++)
		begin
			d[i] = nextRand();
			pushStore(32'h20, SZ_WORD, d[i], idx[i]);
		end
		dispatchLoad(3'd2, idx[1], 1'b0);
		runLoad(3'd2, 32'h20, SZ_HALF, 1'b1, 1'b1, extendLoad(d[1], 2'd0, SZ_HALF, 1'b1), 1'b0);
		drainQueue();
	endtask

	task automatic testPartial();
		data_t   d;
		lsqIdx_t i0;
		lsqIdx_t i1;
		pushStore(32'h31, SZ_BYTE, nextRand(), i0);  // other byte of the word
		dispatchLoad(3'd3, i0, 1'b0);
		runLoad(3'd3, 32'h30, SZ_WORD, 1'b0, 1'b1, mem[12], 1'b1);
		drainQueue();
		d = nextRand();
		pushStore(32'h30, SZ_BYTE, d, i0);
		dispatchLoad(3'd4, i0, 1'b0);
		runLoad(3'd4, 32'h30, SZ_WORD, 1'b0, 1'b1, d, 1'b1);  // replayed after the report
		drainQueue();
		d = nextRand();
		pushStore(32'h32, SZ_BYTE, nextRand(), i0);
		pushStore(32'h30, SZ_WORD, d, i1);  // younger full match covers it
		dispatchLoad(3'd5, i1, 1'b0);
		runLoad(3'd5, 32'h30, SZ_WORD, 1'b0, 1'b1, d, 1'b0);
		drainQueue();
	endtask

	task automatic testStall();
		data_t   d;
		lsqIdx_t i0;
		lsqIdx_t i1;
		d = nextRand();
		pushStore(32'h08, SZ_WORD, d, i0);
		allocStore(i1);
		dispatchLoad(3'd6, i1, 1'b1);
		runLoad(3'd6, 32'h08, SZ_WORD, 1'b0, 1'b0, d, 1'b0);
		dispatchLoad(3'd7, i1, 1'b0);  // no prediction, so forward
		runLoad(3'd7, 32'h08, SZ_WORD, 1'b0, 1'b1, d, 1'b0);
		drainQueue();
		@(negedge clk);
		memOn = 1'b0;
		runLoad(3'd0, 32'h04, SZ_WORD, 1'b0, 1'b0, mem[1], 1'b0);
		memOn = 1'b1;
	endtask

	task automatic testRecover();
		data_t     d0;
		data_t     d1;
		lsqIdx_t   i0;
		lsqIdx_t   i1;
		stCommit_t seen;
		logic      seenEn;
		d0 = nextRand();
		pushStore(32'h14, SZ_WORD, d0, i0);
		dispatchLoad(3'd1, i0, 1'b0);
		runLoad(3'd1, 32'h14, SZ_WORD, 1'b0, 1'b1, d0, 1'b0);
		@(negedge clk);
		recover              = 1'b1;
		addrValidRecover     = '0;
		addrValidRecover[i0] = 1'b1;   // store survives, link does not
		@(negedge clk);
		recover = 1'b0;
		runLoad(3'd1, 32'h14, SZ_WORD, 1'b0, 1'b1, mem[5], 1'b0);
		drainQueue();
		d0 = nextRand();
		d1 = nextRand();
		pushStore(32'h14, SZ_WORD, d0, i0);
		pushStore(32'h14, SZ_WORD, d1, i1);
		dispatchLoad(3'd2, i0, 1'b0);
		runLoad(3'd2, 32'h14, SZ_WORD, 1'b0, 1'b1, d0, 1'b0);
		commitHead(seen, seenEn);  // lastSt leaves the queue
		runLoad(3'd2, 32'h14, SZ_WORD, 1'b0, 1'b1, mem[5], 1'b0);
		drainQueue();
	endtask

	initial
	begin
		clk              = 1'b0;
		reset            = 1'b1;
		ldPkt            = '0;
		stPkt            = '0;
		dispLd           = '0;
		commitSt         = 1'b0;
		commitLdValid    = 1'b0;
		commitLdIdx      = '0;
		stqHead          = '0;
		stqTail          = '0;
		stqCount         = '0;
		recover          = 1'b0;
		addrValidRecover = '0;
		memOn            = 1'b1;
		nextSeq          = '0;
		mismatchCount    = 0;
		failCount        = 0;
		rngState         = 32'd57;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = nextRand();
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		testStoreCommit();
		testMemLoad();
		testForward();
		testPartial();
		testStall();
		testRecover();

		repeat (2) @(negedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* hw/ldDisambig.sv */
// --------------------
// store queue search for one load: forwarding hit, partial overlap and
// predicted-violation stall, all combinational
// --------------------
`timescale 1ns/10ps

module ldDisambig (
	input  ldxPkg::ldPkt_t                ldPkt_i,
	input  ldxPkg::lsqIdx_t               stqHead_i,
	input  ldxPkg::lsqIdx_t               stqTail_i,
	input  ldxPkg::lsqCount_t             stqCount_i,
	input  ldxPkg::wordAddr_t             stqWordAddr_i [ldxPkg::LSQ_DEPTH],
	input  ldxPkg::offset_t               stqOffset_i [ldxPkg::LSQ_DEPTH],
	input  ldxPkg::ldstSize_e             stqSize_i [ldxPkg::LSQ_DEPTH],
	input  logic [ldxPkg::LSQ_DEPTH-1:0]  stqAddrValid_i,
	input  ldxPkg::lsqIdx_t               lastSt_i,
	input  logic                          lastStValid_i,
	input  logic                          predVio_i,
	output ldxPkg::fwdInfo_t              fwd_o
);
	import ldxPkg::*;

	wordAddr_t            ldWordAddr;
	offset_t              ldOffset;
	logic                 lastStInRange;
	logic                 stqWrap;
	logic [LSQ_DEPTH-1:0] windowVec;
	logic [LSQ_DEPTH-1:0] fullMatchVec;
	logic [LSQ_DEPTH-1:0] partialVec;

	assign ldWordAddr = ldPkt_i.addr[ADDR_W-1:OFFSET_W];
	assign ldOffset   = ldPkt_i.addr[OFFSET_W-1:0];

	// full and empty share head == tail, so the count tells them apart
	assign lastStInRange =
		((stqHead_i < stqTail_i) && (lastSt_i >= stqHead_i) && (lastSt_i < stqTail_i)) ||
		((stqTail_i <= stqHead_i) && (stqCount_i != '0) &&
		 ((lastSt_i < stqTail_i) || (lastSt_i >= stqHead_i)));

	assign stqWrap = (stqHead_i > lastSt_i);

	// stores from head up to lastSt are older than the load
	always_comb
	begin
		for (int i = 0; i < LSQ_DEPTH; i++)
		begin
			if (!lastStInRange || !lastStValid_i)
				windowVec[i] = 1'b0;
			else if (stqWrap)
				windowVec[i] = (lsqIdx_t'(i) <= lastSt_i) || (lsqIdx_t'(i) >= stqHead_i);
			else
				windowVec[i] = (lsqIdx_t'(i) >= stqHead_i) && (lsqIdx_t'(i) <= lastSt_i);
		end
	end

	always_comb
	begin
		logic wordHit;

		for (int i = 0; i < LSQ_DEPTH; i++)
		begin
			wordHit         = stqAddrValid_i[i] && windowVec[i] &&
			                  (stqWordAddr_i[i] == ldWordAddr);
			fullMatchVec[i] = wordHit && (stqOffset_i[i] == ldOffset);
			// other bytes, or too few of them
			partialVec[i]   = wordHit &&
			                  ((stqOffset_i[i] != ldOffset) || (stqSize_i[i] < ldPkt_i.size));
		end
	end

	// oldest first, so the last hit seen is the youngest
	always_comb
	begin
		lsqIdx_t idx;

		idx   = stqHead_i;
		fwd_o = '0;
		if (ldPkt_i.valid)
		begin
			for (int k = 0; k < LSQ_DEPTH; k++)
			begin
				idx = stqHead_i + lsqIdx_t'(k);
				if (fullMatchVec[idx])
				begin
					fwd_o.stqHit  = 1'b1;
					fwd_o.fwdIdx  = idx;
					fwd_o.partial = 1'b0;  // older overlaps are covered
				end
				if (partialVec[idx])
					fwd_o.partial = 1'b1;
				if (predVio_i && windowVec[idx] && !stqAddrValid_i[idx])
					fwd_o.stall = 1'b1;    // older address still unknown
			end
		end
	end

	// forwarding source no further from head than lastSt, modulo queue depth
	always_comb
	begin
		if (fwd_o.stqHit)
			assert (lastStValid_i &&
				(lsqIdx_t'(fwd_o.fwdIdx - stqHead_i) <= lsqIdx_t'(lastSt_i - stqHead_i)))
			else $error("forwarding from store %0d outside the window", fwd_o.fwdIdx);
	end

endmodule

/* hw/ldxPath.sv */
// --------------------
// load execution path top: store queue, link table, disambiguation
// and result stage around a single-cycle memory port
// --------------------
`timescale 1ns/10ps

module ldxPath (
	input  logic                          clk,
	input  logic                          reset,
	input  ldxPkg::ldPkt_t                ldPkt_i,
	input  ldxPkg::stPkt_t                stPkt_i,
	input  ldxPkg::dispPkt_t              dispLd_i,
	input  logic                          commitSt_i,
	input  logic                          commitLdValid_i,
	input  ldxPkg::lsqIdx_t               commitLdIdx_i,
	input  ldxPkg::lsqIdx_t               stqHead_i,
	input  ldxPkg::lsqIdx_t               stqTail_i,
	input  ldxPkg::lsqCount_t             stqCount_i,
	input  logic                          recover_i,
	input  logic [ldxPkg::LSQ_DEPTH-1:0]  stqAddrValidRecover_i,
	input  ldxPkg::data_t                 ldData_i,
	input  logic                          ldDataValid_i,
	output logic                          ldEn_o,
	output ldxPkg::addr_t                 ldAddr_o,
	output ldxPkg::stCommit_t             stCommit_o,
	output logic                          stEn_o,
	output ldxPkg::data_t                 loadData_o,
	output logic                          loadValid_o,
	output ldxPkg::ldVio_t                ldVio_o
);
	import ldxPkg::*;

	wordAddr_t            stqWordAddr [LSQ_DEPTH];
	offset_t              stqOffset [LSQ_DEPTH];
	ldstSize_e            stqSize [LSQ_DEPTH];
	logic [LSQ_DEPTH-1:0] stqAddrValid;
	data_t                fwdData;
	lsqIdx_t              lastSt;
	logic                 lastStValid;
	logic                 predVio;
	fwdInfo_t             fwd;

	// memory is read in parallel with the store queue search
	assign ldEn_o   = ldPkt_i.valid;
	assign ldAddr_o = ldPkt_i.addr;
	assign stEn_o   = commitSt_i;

	storeQueue stq (
		.clk                   (clk),
		.reset                 (reset),
		.recover_i             (recover_i),
		.stqAddrValidRecover_i (stqAddrValidRecover_i),
		.stPkt_i               (stPkt_i),
		.commitSt_i            (commitSt_i),
		.stqHead_i             (stqHead_i),
		.fwdIdx_i              (fwd.fwdIdx),
		.stqWordAddr_o         (stqWordAddr),
		.stqOffset_o           (stqOffset),
		.stqSize_o             (stqSize),
		.stqAddrValid_o        (stqAddrValid),
		.fwdData_o             (fwdData),
		.stCommit_o            (stCommit_o)
	);

	loadLinkTable linkTable (
		.clk             (clk),
		.reset           (reset),
		.recover_i       (recover_i),
		.dispLd_i        (dispLd_i),
		.commitSt_i      (commitSt_i),
		.stqHead_i       (stqHead_i),
		.stqCount_i      (stqCount_i),
		.commitLdValid_i (commitLdValid_i),
		.commitLdIdx_i   (commitLdIdx_i),
		.ldIdx_i         (ldPkt_i.lsqId),  // link of the executing load
		.lastSt_o        (lastSt),
		.lastStValid_o   (lastStValid),
		.predVio_o       (predVio)
	);

	ldDisambig disambig (
		.ldPkt_i        (ldPkt_i),
		.stqHead_i      (stqHead_i),
		.stqTail_i      (stqTail_i),
		.stqCount_i     (stqCount_i),
		.stqWordAddr_i  (stqWordAddr),
		.stqOffset_i    (stqOffset),
		.stqSize_i      (stqSize),
		.stqAddrValid_i (stqAddrValid),
		.lastSt_i       (lastSt),
		.lastStValid_i  (lastStValid),
		.predVio_i      (predVio),
		.fwd_o          (fwd)
	);

	loadResult result (
		.clk           (clk),
		.reset         (reset),
		.ldPkt_i       (ldPkt_i),
		.fwd_i         (fwd),
		.fwdData_i     (fwdData),
		.ldData_i      (ldData_i),
		.ldDataValid_i (ldDataValid_i),
		.loadData_o    (loadData_o),
		.loadValid_o   (loadValid_o),
		.ldVio_o       (ldVio_o)
	);

endmodule

/* hw/ldxPkg.sv */
// --------------------
// widths, access sizes and packet structs shared by the load path RTL
// and its testbench, pulled in by a wildcard import
// --------------------
package ldxPkg;

	localparam int DATA_W    = 32;
	localparam int ADDR_W    = 32;
	localparam int OFFSET_W  = 2;  // byte offset within a word
	localparam int LSQ_DEPTH = 8;
	localparam int LSQ_IDX_W = 3;
	localparam int BYTE_EN_W = 4;
	localparam int SEQ_W     = 8;

	typedef logic [DATA_W-1:0]          data_t;
	typedef logic [ADDR_W-1:0]          addr_t;
	typedef logic [ADDR_W-1:OFFSET_W]   wordAddr_t;  // address without byte offset
	typedef logic [OFFSET_W-1:0]        offset_t;
	typedef logic [LSQ_IDX_W-1:0]       lsqIdx_t;
	typedef logic [LSQ_IDX_W:0]         lsqCount_t;  // 0 to LSQ_DEPTH
	typedef logic [BYTE_EN_W-1:0]       byteEn_t;
	typedef logic [SEQ_W-1:0]           seqNo_t;

	// ordered by width so a plain compare finds a narrower store
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_HALF = 2'd1,
		SZ_WORD = 2'd2
	} ldstSize_e;

	// load leaving address generation
	typedef struct packed {
		logic      valid;
		lsqIdx_t   lsqId;
		addr_t     addr;
		ldstSize_e size;
		logic      sign;
		seqNo_t    seqNo;
	} ldPkt_t;

	// store leaving address generation
	typedef struct packed {
		logic      valid;
		lsqIdx_t   lsqId;
		addr_t     addr;
		ldstSize_e size;
		data_t     data;
	} stPkt_t;

	// load entering the load queue
	typedef struct packed {
		logic    valid;
		lsqIdx_t ldqId;
		lsqIdx_t lastSt;   // youngest store older than the load
		logic    predVio;
	} dispPkt_t;

	typedef struct packed {
		addr_t   addr;
		data_t   data;     // register value, not shifted to the offset
		byteEn_t byteEn;
	} stCommit_t;

	typedef struct packed {
		logic   valid;
		seqNo_t seqNo;
	} ldVio_t;

	typedef struct packed {
		logic    stqHit;
		lsqIdx_t fwdIdx;
		logic    partial;
		logic    stall;
	} fwdInfo_t;

endpackage

/* hw/loadLinkTable.sv */
// --------------------
// per-load link to the youngest older store, with its valid flag and
// violation prediction bit; read by the executing load
// --------------------
`timescale 1ns/10ps

module loadLinkTable (
	input  logic                clk,
	input  logic                reset,
	input  logic                recover_i,
	input  ldxPkg::dispPkt_t    dispLd_i,
	input  logic                commitSt_i,
	input  ldxPkg::lsqIdx_t     stqHead_i,
	input  ldxPkg::lsqCount_t   stqCount_i,
	input  logic                commitLdValid_i,
	input  ldxPkg::lsqIdx_t     commitLdIdx_i,
	input  ldxPkg::lsqIdx_t     ldIdx_i,
	output ldxPkg::lsqIdx_t     lastSt_o,
	output logic                lastStValid_o,
	output logic                predVio_o
);
	import ldxPkg::*;

	lsqIdx_t              lastStQ [LSQ_DEPTH];
	logic [LSQ_DEPTH-1:0] linkValidQ;
	logic [LSQ_DEPTH-1:0] linkValidNext;
	logic [LSQ_DEPTH-1:0] predVioQ;
	logic                 stqEmptyNext;

	// queue empty once this cycle's commit is done
	assign stqEmptyNext = ((stqCount_i - lsqCount_t'(commitSt_i)) == '0);

	always_comb
	begin
		linkValidNext = linkValidQ;

		// committing store is no longer in the queue
		if (commitSt_i)
		begin
			for (int i = 0; i < LSQ_DEPTH; i++)
			begin
				if (lastStQ[i] == stqHead_i)
					linkValidNext[i] = 1'b0;
			end
		end

		if (commitLdValid_i)
			linkValidNext[commitLdIdx_i] = 1'b0;

		// a newly dispatched load reuses the slot
		if (dispLd_i.valid)
			linkValidNext[dispLd_i.ldqId] = !stqEmptyNext;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			linkValidQ <= '0;
			predVioQ   <= '0;
			lastStQ    <= '{default: '0};
		end
		else if (recover_i)
		begin
			linkValidQ <= '0;   // every link is dropped
		end
		else
		begin
			linkValidQ <= linkValidNext;
			if (commitLdValid_i)
				predVioQ[commitLdIdx_i] <= 1'b0;
			if (dispLd_i.valid)
			begin
				lastStQ[dispLd_i.ldqId]  <= dispLd_i.lastSt;
				predVioQ[dispLd_i.ldqId] <= dispLd_i.predVio;
			end
		end
	end

	assign lastSt_o      = lastStQ[ldIdx_i];
	assign lastStValid_o = linkValidQ[ldIdx_i];
	assign predVio_o     = predVioQ[ldIdx_i];

endmodule

/* hw/loadResult.sv */
// --------------------
// picks forwarded or memory data, extends it by size and registers
// the load result and violation report
// --------------------
`timescale 1ns/10ps

module loadResult (
	input  logic              clk,
	input  logic              reset,
	input  ldxPkg::ldPkt_t    ldPkt_i,
	input  ldxPkg::fwdInfo_t  fwd_i,
	input  ldxPkg::data_t     fwdData_i,
	input  ldxPkg::data_t     ldData_i,
	input  logic              ldDataValid_i,
	output ldxPkg::data_t     loadData_o,
	output logic              loadValid_o,
	output ldxPkg::ldVio_t    ldVio_o
);
	import ldxPkg::*;

	data_t  memAligned;
	data_t  rawData;
	data_t  extData;
	logic   vioValidQ;
	seqNo_t vioSeqQ;

	// memory returns the whole word; move the addressed bytes down
	assign memAligned = ldData_i >> {ldPkt_i.addr[OFFSET_W-1:0], 3'b000};
	assign rawData    = fwd_i.stqHit ? fwdData_i : memAligned;

	always_comb
	begin
		case (ldPkt_i.size)
			SZ_BYTE: extData = {{(DATA_W-8){ldPkt_i.sign & rawData[7]}}, rawData[7:0]};
			SZ_HALF: extData = {{(DATA_W-16){ldPkt_i.sign & rawData[15]}}, rawData[15:0]};
			default: extData = rawData;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			loadValid_o <= 1'b0;
			vioValidQ   <= 1'b0;
		end
		else
		begin
			// no data from either source means the issuer replays
			loadValid_o <= ldPkt_i.valid && (fwd_i.stqHit || ldDataValid_i) && !fwd_i.stall;
			vioValidQ   <= ldPkt_i.valid && fwd_i.partial;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ldPkt_i.valid)
		begin
			loadData_o <= extData;
			vioSeqQ    <= ldPkt_i.seqNo;
		end
	end

	assign ldVio_o.valid = vioValidQ;
	assign ldVio_o.seqNo = vioSeqQ;

	assert property (@(posedge clk) disable iff (reset)
		!$isunknown({loadValid_o, vioValidQ}))
		else $error("load result handshake is unknown");

	// a reported result carries known data and sequence number
	assert property (@(posedge clk) disable iff (reset)
		(loadValid_o |-> !$isunknown(loadData_o)) and (vioValidQ |-> !$isunknown(vioSeqQ)))
		else $error("valid load result with unknown payload");

endmodule

/* hw/storeQueue.sv */
// --------------------
// store queue entries; written at store execute, head sent to memory
// with byte enables on commit
// --------------------
`timescale 1ns/10ps

module storeQueue (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          recover_i,
	input  logic [ldxPkg::LSQ_DEPTH-1:0]  stqAddrValidRecover_i,
	input  ldxPkg::stPkt_t                stPkt_i,
	input  logic                          commitSt_i,
	input  ldxPkg::lsqIdx_t               stqHead_i,
	input  ldxPkg::lsqIdx_t               fwdIdx_i,
	output ldxPkg::wordAddr_t             stqWordAddr_o [ldxPkg::LSQ_DEPTH],
	output ldxPkg::offset_t               stqOffset_o [ldxPkg::LSQ_DEPTH],
	output ldxPkg::ldstSize_e             stqSize_o [ldxPkg::LSQ_DEPTH],
	output logic [ldxPkg::LSQ_DEPTH-1:0]  stqAddrValid_o,
	output ldxPkg::data_t                 fwdData_o,
	output ldxPkg::stCommit_t             stCommit_o
);
	import ldxPkg::*;

	wordAddr_t            wordAddrQ [LSQ_DEPTH];
	offset_t              offsetQ [LSQ_DEPTH];
	ldstSize_e            sizeQ [LSQ_DEPTH];
	data_t                dataQ [LSQ_DEPTH];
	logic [LSQ_DEPTH-1:0] addrValidQ;
	offset_t              headOffset;
	byteEn_t              headByteEn;

	// entry payload
	always_ff @(posedge clk)
	begin
		if (stPkt_i.valid && !recover_i)
		begin
			wordAddrQ[stPkt_i.lsqId] <= stPkt_i.addr[ADDR_W-1:OFFSET_W];
			offsetQ[stPkt_i.lsqId]   <= stPkt_i.addr[OFFSET_W-1:0];
			sizeQ[stPkt_i.lsqId]     <= stPkt_i.size;
			dataQ[stPkt_i.lsqId]     <= stPkt_i.data;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			addrValidQ <= '0;
		end
		else if (recover_i)
		begin
			addrValidQ <= stqAddrValidRecover_i;  // surviving stores only
		end
		else
		begin
			if (commitSt_i)
				addrValidQ[stqHead_i] <= 1'b0;   // head leaves the queue
			if (stPkt_i.valid)
				addrValidQ[stPkt_i.lsqId] <= 1'b1;
		end
	end

	// byte enables of the head store
	always_comb
	begin
		headOffset = offsetQ[stqHead_i];
		case (sizeQ[stqHead_i])
			SZ_BYTE: headByteEn = byteEn_t'(4'b0001) << headOffset;
			SZ_HALF: headByteEn = byteEn_t'(4'b0011) << headOffset;
			default: headByteEn = '1;
		endcase
	end

	assign stCommit_o.addr   = {wordAddrQ[stqHead_i], headOffset};
	assign stCommit_o.data   = dataQ[stqHead_i];
	assign stCommit_o.byteEn = headByteEn;

	assign stqWordAddr_o  = wordAddrQ;
	assign stqOffset_o    = offsetQ;
	assign stqSize_o      = sizeQ;
	assign stqAddrValid_o = addrValidQ;
	assign fwdData_o      = dataQ[fwdIdx_i];   // unshifted, as the store wrote it

	// retire and execute must never target the same entry in one cycle
	assert property (@(posedge clk) disable iff (reset)
		!(commitSt_i && stPkt_i.valid && (stPkt_i.lsqId == stqHead_i)))
		else $error("store execute and commit on the same entry %0d", stqHead_i);

endmodule

/* ldxPath.f */
hw/ldxPkg.sv
hw/storeQueue.sv
hw/loadLinkTable.sv
hw/ldDisambig.sv
hw/loadResult.sv
hw/ldxPath.sv
dv/ldxPathTb.sv

/* run.sh */
#!/bin/sh
# build the load path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ldxPathTb -f ldxPath.f -o ldxPathSim

status=0
./obj_dir/ldxPathSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
